//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_match_game
RTL_TOP   ?= match_game_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- game_pkg.sv
`default_nettype none
`include "game_settings.svh"

package game_pkg;

    // Round sequence, start button walks through it
    typedef enum logic [1:0] {
        ST_INIT   = 2'd0,
        ST_SHOW   = 2'd1,
        ST_GAME   = 2'd2,
        ST_FINISH = 2'd3
    } game_state_t;

    typedef logic [$clog2(`NUM_TILES)-1:0] tile_idx_t;

    // One bit per tile, bit t is tile t
    typedef logic [`NUM_TILES-1:0] tile_mask_t;

    // Must reach NUM_IMAGES
    typedef logic [$clog2(`NUM_IMAGES+1)-1:0] match_cnt_t;

    // Tiles 0, 2 and 3 start upside down
    localparam tile_mask_t INIT_FLIP = tile_mask_t'(4'b1101);

endpackage

`default_nettype wire

//--- game_settings.svh
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// Board of 4 by 4 tiles
`define NUM_TILES 16

// Each image sits on two tiles
`define NUM_IMAGES 8

// Cycles the start button has to stay high
`define DEBOUNCE_LEN 7

// Event slots between keyboard side and game, power of two
`define EVT_FIFO_DEPTH 4

`endif

//--- key_event_fifo.sv
`default_nettype none
`timescale 1ns/10ps
`include "game_settings.svh"

module key_event_fifo #(
    parameter int DEPTH = `EVT_FIFO_DEPTH
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  in_req_i,
    input  key_pkg::key_event_t  in_event_i,
    output logic                 in_ack_o,
    output logic                 out_req_o,
    output key_pkg::key_event_t  out_event_o,
    input  wire                  out_ack_i
);
    import key_pkg::*;

    localparam int AW = $clog2(DEPTH);

    key_event_t   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          in_ack_q;
    logic          out_req_q;
    logic          out_wait_q;
    logic          push;
    logic          pop;

    if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
        $error("key_event_fifo DEPTH must be a power of two, at least 2");
    end

    // Full holds off the ack
    assign push = in_req_i && !in_ack_q && (count != (AW+1)'(DEPTH));
    assign pop  = out_req_q && out_ack_i;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_event_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Receive side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_ack_q <= 1'b0;
        end else if (push) begin
            in_ack_q <= 1'b1;
        end else if (in_ack_q && !in_req_i) begin
            in_ack_q <= 1'b0;
        end
    end

    // Send side, head entry stays put until it is popped
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_req_q  <= 1'b0;
            out_wait_q <= 1'b0;
        end else if (pop) begin
            out_req_q  <= 1'b0;
            out_wait_q <= 1'b1;
        end else if (out_wait_q) begin
            if (!out_ack_i) begin
                out_wait_q <= 1'b0;
            end
        end else if (!out_req_q && count != '0) begin
            out_req_q <= 1'b1;
        end
    end

    assign in_ack_o    = in_ack_q;
    assign out_req_o   = out_req_q;
    assign out_event_o = mem[rd_ptr];

    count_bound_a: assert property (@(posedge clk) disable iff (rst)
        count <= (AW+1)'(DEPTH));

    out_held_a: assert property (@(posedge clk) disable iff (rst)
        out_req_o && $past(out_req_o) |-> $stable(out_event_o));

endmodule

`default_nettype wire

//--- key_event_source.sv
`default_nettype none
`timescale 1ns/10ps
`include "game_settings.svh"

module key_event_source (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  start_i,
    input  wire                  key_valid_i,
    input  wire  [7:0]           key_code_i,
    input  wire                  ack_i,
    output logic                 req_o,
    output key_pkg::key_event_t  event_o
);
    import key_pkg::*;

    logic [`DEBOUNCE_LEN-1:0] db_sr;
    logic                     start_db;
    logic                     start_db_q;
    logic                     start_pulse;
    logic                     key_hit;
    key_event_t               key_evt;
    logic                     req_q;
    logic                     busy_q;
    key_event_t               event_q;

    // Button counts as pressed once every sample in the window is high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            db_sr      <= '0;
            start_db_q <= 1'b0;
        end else begin
            db_sr      <= {db_sr[`DEBOUNCE_LEN-2:0], start_i};
            start_db_q <= start_db;
        end
    end

    assign start_db    = &db_sr;
    assign start_pulse = start_db & ~start_db_q;

    // Scan code lookup
    always_comb begin
        key_hit      = 1'b0;
        key_evt.kind = KEY_TILE;
        key_evt.tile = '0;
        if (key_valid_i) begin
            if (key_code_i == SC_SHIFT) begin
                key_hit      = 1'b1;
                key_evt.kind = KEY_SHIFT;
            end else if (key_code_i == SC_ENTER) begin
                key_hit      = 1'b1;
                key_evt.kind = KEY_ENTER;
            end else begin
                for (int t = 0; t < `NUM_TILES; t++) begin
                    if (key_code_i == TILE_CODES[t]) begin
                        key_hit      = 1'b1;
                        key_evt.tile = TILE_W'(t);
                    end
                end
            end
        end
    end

    // Sender: idle, req high until ack, then wait for ack to fall
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q  <= 1'b0;
            busy_q <= 1'b0;
        end else if (!busy_q) begin
            if (start_pulse || key_hit) begin
                req_q  <= 1'b1;
                busy_q <= 1'b1;
            end
        end else if (req_q) begin
            if (ack_i) begin
                req_q <= 1'b0;
            end
        end else if (!ack_i) begin
            busy_q <= 1'b0;
        end
    end

    // Start has priority over a key in the same cycle
    always_ff @(posedge clk) begin
        if (!busy_q && start_pulse) begin
            event_q.kind <= KEY_START;
            event_q.tile <= '0;
        end else if (!busy_q && key_hit) begin
            event_q <= key_evt;
        end
    end

    assign req_o   = req_q;
    assign event_o = event_q;

    event_held_a: assert property (@(posedge clk) disable iff (rst)
        req_o && $past(req_o) |-> $stable(event_o));

endmodule

`default_nettype wire

//--- key_pkg.sv
`default_nettype none
`include "game_settings.svh"

package key_pkg;

    localparam int TILE_W = $clog2(`NUM_TILES);

    // What an event asks the game to do
    typedef enum logic [1:0] {
        KEY_TILE  = 2'd0,
        KEY_SHIFT = 2'd1,
        KEY_ENTER = 2'd2,
        KEY_START = 2'd3
    } key_kind_t;

    // Tile is only meaningful for KEY_TILE
    typedef struct packed {
        key_kind_t          kind;
        logic [TILE_W-1:0]  tile;
    } key_event_t;

    // Set 2 make codes
    localparam logic [7:0] SC_SHIFT = 8'h12;
    localparam logic [7:0] SC_ENTER = 8'h5A;

    // Index in this table is the tile number
    localparam logic [7:0] TILE_CODES [`NUM_TILES] = '{
        // 1 2 3 4
        8'h16, 8'h1E, 8'h26, 8'h25,
        // Q W E R
        8'h15, 8'h1D, 8'h24, 8'h2D,
        // A S D F
        8'h1C, 8'h1B, 8'h23, 8'h2B,
        // Z X C V
        8'h1A, 8'h22, 8'h21, 8'h2A
    };

endpackage

`default_nettype wire

//--- match_game_ctrl.sv
`default_nettype none
`timescale 1ns/10ps
`include "game_settings.svh"

module match_game_ctrl (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   evt_req_i,
    input  key_pkg::key_event_t   evt_event_i,
    input  wire                   hint_i,
    output logic                  evt_ack_o,
    output game_pkg::game_state_t state_o,
    output game_pkg::tile_mask_t  shown_o,
    output game_pkg::tile_mask_t  flip_o,
    output game_pkg::match_cnt_t  match_cnt_o,
    output logic                  pass_o
);
    import key_pkg::*;
    import game_pkg::*;

    game_state_t state_q;
    tile_mask_t  matched_q;
    tile_mask_t  revealed_q;
    tile_mask_t  flip_q;
    tile_mask_t  shown_q;
    tile_idx_t   pend_q;
    logic        pend_valid_q;
    logic        arm_flip_q;
    match_cnt_t  match_cnt_q;
    logic        evt_ack_q;
    logic        apply;
    tile_idx_t   ev_tile;

    function automatic logic same_image(tile_idx_t a, tile_idx_t b);
        return (int'(a) % `NUM_IMAGES) == (int'(b) % `NUM_IMAGES);
    endfunction

    // Ack the cycle after req, and take the event in that cycle
    assign apply   = evt_req_i && !evt_ack_q;
    assign ev_tile = evt_event_i.tile;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            evt_ack_q <= 1'b0;
        end else if (apply) begin
            evt_ack_q <= 1'b1;
        end else if (!evt_req_i) begin
            evt_ack_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= ST_INIT;
            matched_q    <= '0;
            revealed_q   <= '0;
            flip_q       <= INIT_FLIP;
            pend_q       <= '0;
            pend_valid_q <= 1'b0;
            arm_flip_q   <= 1'b0;
            match_cnt_q  <= '0;
        end else if (apply && evt_event_i.kind == KEY_START && state_q != ST_GAME) begin
            if (state_q == ST_SHOW) begin
                state_q <= ST_GAME;
            end else begin
                // Fresh board when entering INIT or SHOW
                state_q      <= (state_q == ST_INIT) ? ST_SHOW : ST_INIT;
                matched_q    <= '0;
                revealed_q   <= '0;
                flip_q       <= INIT_FLIP;
                pend_q       <= '0;
                pend_valid_q <= 1'b0;
                arm_flip_q   <= 1'b0;
                match_cnt_q  <= '0;
            end
        end else if (state_q == ST_GAME) begin
            if (match_cnt_q == match_cnt_t'(`NUM_IMAGES)) begin
                state_q <= ST_FINISH;
            end else if (apply) begin
                case (evt_event_i.kind)
                    KEY_TILE: begin
                        // Same key as the pending tile does nothing
                        if (!(pend_valid_q && pend_q == ev_tile)) begin
                            revealed_q[ev_tile] <= 1'b1;
                            pend_q              <= ev_tile;
                            pend_valid_q        <= 1'b1;
                            if (arm_flip_q) begin
                                flip_q[ev_tile] <= ~flip_q[ev_tile];
                                arm_flip_q      <= 1'b0;
                            end else if (pend_valid_q && !matched_q[pend_q]
                                         && same_image(pend_q, ev_tile)
                                         && flip_q[pend_q] == flip_q[ev_tile]) begin
                                matched_q[pend_q]  <= 1'b1;
                                matched_q[ev_tile] <= 1'b1;
                                match_cnt_q        <= match_cnt_q + 1'b1;
                            end
                        end
                    end
                    KEY_SHIFT: begin
                        if (pend_valid_q) begin
                            flip_q[pend_q] <= ~flip_q[pend_q];
                        end else begin
                            arm_flip_q <= 1'b1;
                        end
                    end
                    KEY_ENTER: begin
                        // Matched tiles stay visible through matched_q
                        revealed_q   <= '0;
                        pend_valid_q <= 1'b0;
                        arm_flip_q   <= 1'b0;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Display mask, hint takes effect one cycle later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shown_q <= '0;
        end else begin
            case (state_q)
                ST_INIT: shown_q <= '0;
                ST_GAME: shown_q <= hint_i ? '1 : (matched_q | revealed_q);
                default: shown_q <= '1;
            endcase
        end
    end

    assign evt_ack_o   = evt_ack_q;
    assign state_o     = state_q;
    assign shown_o     = shown_q;
    assign flip_o      = flip_q;
    assign match_cnt_o = match_cnt_q;
    assign pass_o      = (state_q == ST_FINISH);

    // Tile t and t + NUM_IMAGES share an image, and each pair counts once
    pairs_matched_a: assert property (@(posedge clk) disable iff (rst)
        (matched_q[`NUM_IMAGES-1:0] == matched_q[`NUM_TILES-1:`NUM_IMAGES])
        && ($countones(matched_q) == 2 * int'(match_cnt_q)));

endmodule

`default_nettype wire

//--- match_game_top.sv
`default_nettype none
`timescale 1ns/10ps

module match_game_top (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   start_i,
    input  wire                   key_valid_i,
    input  wire  [7:0]            key_code_i,
    input  wire                   hint_i,
    output game_pkg::game_state_t state_o,
    output game_pkg::tile_mask_t  shown_o,
    output game_pkg::tile_mask_t  flip_o,
    output game_pkg::match_cnt_t  match_cnt_o,
    output logic                  pass_o
);
    import key_pkg::*;

    // Keyboard side to buffer
    logic       src_req;
    logic       src_ack;
    key_event_t src_event;

    // Buffer to game
    logic       evt_req;
    logic       evt_ack;
    key_event_t evt_event;

    key_event_source u_source (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_i),
        .key_valid_i (key_valid_i),
        .key_code_i  (key_code_i),
        .ack_i       (src_ack),
        .req_o       (src_req),
        .event_o     (src_event)
    );

    key_event_fifo u_fifo (
        .clk         (clk),
        .rst         (rst),
        .in_req_i    (src_req),
        .in_event_i  (src_event),
        .in_ack_o    (src_ack),
        .out_req_o   (evt_req),
        .out_event_o (evt_event),
        .out_ack_i   (evt_ack)
    );

    match_game_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .evt_req_i   (evt_req),
        .evt_event_i (evt_event),
        .hint_i      (hint_i),
        .evt_ack_o   (evt_ack),
        .state_o     (state_o),
        .shown_o     (shown_o),
        .flip_o      (flip_o),
        .match_cnt_o (match_cnt_o),
        .pass_o      (pass_o)
    );

endmodule

`default_nettype wire

//--- match_game_vectors.txt
// op_arg_state_shown_flip_count_pass, all hex
// op 0 check, 1 start press, 2 key code, 3 hint level, E end of test, F end
0_00_0_0000_000D_0_0
1_00_1_FFFF_000D_0_0
1_00_2_0000_000D_0_0
E_01_0_0000_0000_0_0
// Tiles 0 and 8 share an image but differ in flip
2_16_2_0001_000D_0_0
2_1C_2_0101_000D_0_0
2_5A_2_0000_000D_0_0
E_02_0_0000_0000_0_0
// Flip tile 8, then tile 0 matches it
2_1C_2_0100_000D_0_0
2_12_2_0100_010D_0_0
2_16_2_0101_010D_1_0
2_5A_2_0101_010D_1_0
E_03_0_0000_0000_0_0
// Armed flip on tile 1, no match with tile 9, unknown code
2_12_2_0101_010D_1_0
2_1E_2_0103_010F_1_0
2_1B_2_0303_010F_1_0
2_77_2_0303_010F_1_0
2_5A_2_0101_010F_1_0
E_04_0_0000_0000_0_0
// Hint
3_01_2_FFFF_010F_1_0
3_00_2_0101_010F_1_0
E_05_0_0000_0000_0_0
// Remaining pairs
2_1E_2_0103_010F_1_0
2_12_2_0103_010D_1_0
2_1B_2_0303_010D_2_0
2_26_2_0307_010D_2_0
2_12_2_0307_0109_2_0
2_23_2_0707_0109_3_0
2_25_2_070F_0109_3_0
2_12_2_070F_0101_3_0
2_2B_2_0F0F_0101_4_0
2_15_2_0F1F_0101_4_0
2_1A_2_1F1F_0101_5_0
2_1D_2_1F3F_0101_5_0
2_22_2_3F3F_0101_6_0
2_24_2_3F7F_0101_6_0
2_21_2_7F7F_0101_7_0
2_2D_2_7FFF_0101_7_0
2_2A_3_FFFF_0101_8_1
1_00_0_0000_000D_0_0
E_06_0_0000_0000_0_0
F_00_0_0000_0000_0_0

//--- project.f
+incdir+.
key_pkg.sv
game_pkg.sv
key_event_source.sv
key_event_fifo.sv
match_game_ctrl.sv
match_game_top.sv
tb_match_game.sv

//--- tb_match_game.sv
`default_nettype none
`timescale 1ns/10ps

module tb_match_game;

    localparam int MAX_VECS    = 64;
    localparam int WAIT_CYCLES = 30;
    localparam int GAP_CYCLES  = 16;

    logic        clk;
    logic        rst;
    logic        start_i;
    logic        key_valid_i;
    logic [7:0]  key_code_i;
    logic        hint_i;
    logic [1:0]  state_o;
    logic [15:0] shown_o;
    logic [15:0] flip_o;
    logic [3:0]  match_cnt_o;
    logic        pass_o;

    // op, arg, state, shown, flip, match count, pass
    logic [55:0] vecs [MAX_VECS];
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    match_game_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_i),
        .key_valid_i (key_valid_i),
        .key_code_i  (key_code_i),
        .hint_i      (hint_i),
        .state_o     (state_o),
        .shown_o     (shown_o),
        .flip_o      (flip_o),
        .match_cnt_o (match_cnt_o),
        .pass_o      (pass_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Inputs change 10 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    function automatic bit outputs_match(input logic [55:0] v);
        return ({2'b00, state_o} === v[43:40]) && (shown_o === v[39:24])
            && (flip_o === v[23:8]) && (match_cnt_o === v[7:4])
            && ({3'b000, pass_o} === v[3:0]);
    endfunction

    task automatic press_start();
        start_i = 1'b1;
        repeat (10) step();
        start_i = 1'b0;
    endtask

    task automatic send_key(input logic [7:0] code);
        key_valid_i = 1'b1;
        key_code_i  = code;
        step();
        key_valid_i = 1'b0;
    endtask

    task automatic check_outputs(input logic [55:0] v);
        check_value("state_o", 16'(state_o), 16'(v[43:40]));
        check_value("shown_o", shown_o, v[39:24]);
        check_value("flip_o", flip_o, v[23:8]);
        check_value("match_cnt_o", 16'(match_cnt_o), 16'(v[7:4]));
        check_value("pass_o", 16'(pass_o), 16'(v[3:0]));
    endtask

    task automatic wait_outputs(input int idx, input logic [55:0] v);
        int cycles;
        cycles = 0;
        while (cycles < WAIT_CYCLES && !outputs_match(v)) begin
            step();
            cycles++;
        end
        if (!outputs_match(v)) begin
            $display("Outputs did not settle within %0d cycles at vector %0d", WAIT_CYCLES, idx);
        end
        check_outputs(v);
    endtask

    initial begin
        logic [3:0] op;
        logic [7:0] arg;
        bit         done;
        rst          = 1'b1;
        start_i      = 1'b0;
        key_valid_i  = 1'b0;
        key_code_i   = 8'h00;
        hint_i       = 1'b0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        done         = 1'b0;
        $readmemh("match_game_vectors.txt", vecs);
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
        for (int n = 0; n < MAX_VECS && !done; n++) begin
            op  = vecs[n][55:52];
            arg = vecs[n][51:44];
            case (op)
                4'h0: wait_outputs(n, vecs[n]);
                4'h1: press_start();
                4'h2: send_key(arg);
                4'h3: hint_i = arg[0];
                4'hE: begin
                    tests_run++;
                    if (test_errors == 0) begin
                        $display("test %0d ok", arg);
                    end else begin
                        $display("test %0d had %0d errors", arg, test_errors);
                        tests_failed++;
                    end
                    test_errors = 0;
                end
                4'hF: done = 1'b1;
                default: begin
                    $display("Unknown operation %h in vector %0d", op, n);
                    errors++;
                    done = 1'b1;
                end
            endcase
            // Events get a quiet gap so the source never drops a strobe
            if (op inside {4'h1, 4'h2, 4'h3}) begin
                wait_outputs(n, vecs[n]);
                repeat (GAP_CYCLES) step();
                // By now the event has certainly reached the game
                check_outputs(vecs[n]);
            end
        end
        if (!done) begin
            $display("Vector file has no end marker");
            errors++;
        end
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
